// File: hdl/ahb_mtx_params.svh
`ifndef AHB_MTX_PARAMS_SVH
`define AHB_MTX_PARAMS_SVH

// ------------------------------------------------
// Bus widths of the shared slave port
// ------------------------------------------------
`define AHB_ADDR_W    32  // HADDR width
`define AHB_DATA_W    32  // HWDATA width
`define AHB_MASTER_W  4   // HMASTER width
`define AHB_PROT_W    4   // HPROT width

// ------------------------------------------------
// Matrix shape
// ------------------------------------------------
`define MTX_NUM_PORTS 3   // Input ports sharing this slave

`endif

// File: hdl/ahb_mtx_pkg.sv
`include "ahb_mtx_params.svh"

package ahb_mtx_pkg;

  // ------------------------------------------------
  // AHB transfer type
  // ------------------------------------------------
  typedef enum logic [1:0] {
    IDLE   = 2'b00,  // No transfer
    BUSY   = 2'b01,  // Burst paused by master
    NONSEQ = 2'b10,  // Single or first beat
    SEQ    = 2'b11   // Remaining burst beats
  } htrans_e;

  // Input port identity, zero code unused
  typedef enum logic [1:0] {
    PORT_1 = 2'd1,
    PORT_2 = 2'd2,
    PORT_3 = 2'd3
  } port_id_e;

  // ------------------------------------------------
  // Address phase control of one port
  // ------------------------------------------------
  typedef struct packed {
    logic [`AHB_ADDR_W-1:0]   addr;      // HADDR
    logic                     write;     // HWRITE
    logic [2:0]               size;      // HSIZE
    logic [2:0]               burst;     // HBURST, passed through
    logic [`AHB_PROT_W-1:0]   prot;      // HPROT
    logic [`AHB_MASTER_W-1:0] master;    // HMASTER
    logic                     mastlock;  // HMASTLOCK
    htrans_e                  trans;     // HTRANS
  } ahb_ctrl_t;

endpackage

// File: hdl/ahb_mtx_arb_if.sv
`timescale 1ns/1ps

interface ahb_mtx_arb_if
  import ahb_mtx_pkg::*;
();

  port_id_e grant;     // Registered owner of the address phase
  logic     no_port;   // No port granted
  logic     sel;       // Owner's select
  htrans_e  trans;     // Owner's transfer type
  logic     mastlock;  // Owner's lock

  // Arbiter side
  modport arb (
    output grant,
    output no_port,
    input  sel,
    input  trans,
    input  mastlock
  );

  // Address multiplexer side, returns owner state
  modport mux (
    input  grant,
    input  no_port,
    output sel,
    output trans,
    output mastlock
  );

  // Data phase only observes
  modport watch (
    input grant,
    input no_port,
    input sel
  );

endinterface

// File: hdl/ahb_mtx_output_arb.sv
`timescale 1ns/1ps
`include "ahb_mtx_params.svh"

module ahb_mtx_output_arb
  import ahb_mtx_pkg::*;
(
  input  logic                      HCLK,          // AHB clock
  input  logic                      HRESETn,       // Sync reset, active low
  input  logic [`MTX_NUM_PORTS-1:0] i_req,         // Held transfer and select per port
  input  logic                      i_hready_mux,  // Slave side transfer done
  ahb_mtx_arb_if.arb                arb            // Grant out, owner state back
);

  port_id_e   grant_q;        // Grant, doubles as last owner pointer
  port_id_e   grant_nxt;      // Next grant
  logic       no_port_q;      // Nothing granted
  logic       no_port_nxt;    // Next no_port
  logic       lock_hold_q;    // Locked sequence in progress
  logic       lock_hold_nxt;  // Next lock hold
  logic       lock_arb;       // Lock as seen by arbitration
  logic       burst_hold;     // Owner inside a burst
  logic [1:0] owner_idx;      // Owner as bit index
  logic [1:0] cand_idx;       // Port under test in the scan

  assign owner_idx = grant_q - 2'd1;  // Codes 1..3 to bits 0..2

  // ------------------------------------------------
  // Lock hold
  // ------------------------------------------------
  // A master may leave this slave briefly inside a locked sequence,
  // so lock seen once with select keeps counting until mastlock drops
  always_comb
  begin
    lock_hold_nxt = lock_hold_q;                       // Keep by default
    if (arb.sel && arb.mastlock && (arb.trans == NONSEQ || arb.trans == SEQ))
      lock_hold_nxt = 1'b1;                            // Locked transfer started
    else if (!arb.mastlock)
      lock_hold_nxt = 1'b0;                            // Sequence over
  end

  assign lock_arb = arb.mastlock & (lock_hold_q | arb.sel);  // Masked unless held

  // Owner still mid burst
  assign burst_hold = i_req[owner_idx] & ~no_port_q &
                      ((arb.trans == SEQ) | (arb.trans == BUSY));

  // ------------------------------------------------
  // Round robin
  // ------------------------------------------------
  always_comb
  begin
    grant_nxt   = grant_q;     // Grant keeps last value when idle
    no_port_nxt = 1'b1;
    cand_idx    = owner_idx;
    if (burst_hold || lock_arb)
    begin
      no_port_nxt = 1'b0;      // Owner keeps the slave
    end
    else
    begin
      // Scan from far to near, so nearest requester after owner wins
      for (int k = `MTX_NUM_PORTS; k >= 1; k--)
      begin
        cand_idx = 2'((int'(owner_idx) + k) % `MTX_NUM_PORTS);  // Wrap 3 to 1
        if (i_req[cand_idx])
        begin
          grant_nxt   = port_id_e'(cand_idx + 2'd1);
          no_port_nxt = 1'b0;
        end
      end
    end
  end

  // ------------------------------------------------
  // State registers
  // ------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      grant_q     <= PORT_3;   // Port 1 is next in line
      no_port_q   <= 1'b1;
      lock_hold_q <= 1'b0;
    end
    else if (i_hready_mux)     // Frozen during wait states
    begin
      grant_q     <= grant_nxt;
      no_port_q   <= no_port_nxt;
      lock_hold_q <= lock_hold_nxt;
    end
  end

  assign arb.grant   = grant_q;
  assign arb.no_port = no_port_q;

endmodule

// File: hdl/ahb_mtx_addr_mux.sv
`timescale 1ns/1ps
`include "ahb_mtx_params.svh"

module ahb_mtx_addr_mux
  import ahb_mtx_pkg::*;
(
  input  ahb_ctrl_t                 i_ctrl [`MTX_NUM_PORTS],  // Control per port
  input  logic [`MTX_NUM_PORTS-1:0] i_sel,                    // Select per port
  ahb_mtx_arb_if.mux                mux,                      // Grant in, owner state out
  output ahb_ctrl_t                 o_ctrl,                   // Slave address and control
  output logic                      o_sel,                    // HSELM
  output logic [`MTX_NUM_PORTS-1:0] o_active                  // One hot owner flags
);

  logic [1:0] grant_idx;  // Granted port as array index

  assign grant_idx = mux.grant - 2'd1;

  // ------------------------------------------------
  // Active flags
  // ------------------------------------------------
  always_comb
  begin
    o_active = '0;                  // None when idle
    if (!mux.no_port)
    begin
      case (mux.grant)
        PORT_1  : o_active[0] = 1'b1;
        PORT_2  : o_active[1] = 1'b1;
        PORT_3  : o_active[2] = 1'b1;
        default : o_active    = '0;  // Unused code
      endcase
    end
  end

  // ------------------------------------------------
  // Address and control select
  // ------------------------------------------------
  always_comb
  begin
    o_ctrl       = '0;              // Zero address and control
    o_ctrl.trans = IDLE;            // Idle slave when nobody owns it
    o_sel        = 1'b0;
    if (!mux.no_port)
    begin
      o_ctrl = i_ctrl[grant_idx];   // Owner's fields, burst untouched
      o_sel  = i_sel[grant_idx];    // May be low mid locked sequence
    end
  end

  // Owner state back to the arbiter
  assign mux.sel      = o_sel;
  assign mux.trans    = o_ctrl.trans;
  assign mux.mastlock = o_ctrl.mastlock;

endmodule

// File: hdl/ahb_mtx_data_phase.sv
`timescale 1ns/1ps
`include "ahb_mtx_params.svh"

module ahb_mtx_data_phase
  import ahb_mtx_pkg::*;
(
  input  logic                   HCLK,                     // AHB clock
  input  logic                   HRESETn,                  // Sync reset, active low
  input  logic                   i_hreadyout,              // Slave HREADYOUT
  input  logic [`AHB_DATA_W-1:0] i_wdata [`MTX_NUM_PORTS], // Write data per port
  ahb_mtx_arb_if.watch           watch,                    // Address phase owner
  output logic                   o_hready_mux,             // HREADYMUXM
  output logic [`AHB_DATA_W-1:0] o_wdata                   // HWDATAM
);

  port_id_e   data_port_q;  // Owner of the current data phase
  logic       slave_sel_q;  // Slave selected in the data phase
  logic [1:0] data_idx;     // Data phase owner as array index

  // ------------------------------------------------
  // Data phase registers
  // ------------------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_port_q <= PORT_3;                          // Matches arbiter reset grant
      slave_sel_q <= 1'b0;
    end
    else if (o_hready_mux)                            // Address phase completes
    begin
      data_port_q <= watch.grant;
      slave_sel_q <= watch.sel & ~watch.no_port;      // Only a real owner selects
    end
  end

  // Slave drives ready only when it owns the data phase
  assign o_hready_mux = slave_sel_q ? i_hreadyout : 1'b1;

  // ------------------------------------------------
  // Write data select
  // ------------------------------------------------
  assign data_idx = data_port_q - 2'd1;               // Codes 1..3 to 0..2
  assign o_wdata  = i_wdata[data_idx];                // Stable while ready low

endmodule

// File: hdl/ahb_mtx_output_stage.sv
`timescale 1ns/1ps
`include "ahb_mtx_params.svh"

module ahb_mtx_output_stage
  import ahb_mtx_pkg::*;
(
  input  logic                      HCLK,                          // AHB clock
  input  logic                      HRESETn,                       // Sync reset, active low

  // Input ports
  input  logic [`MTX_NUM_PORTS-1:0] i_sel,                         // HSEL
  input  logic [`AHB_ADDR_W-1:0]    i_addr      [`MTX_NUM_PORTS],  // HADDR
  input  htrans_e                   i_trans     [`MTX_NUM_PORTS],  // HTRANS
  input  logic [`MTX_NUM_PORTS-1:0] i_write,                       // HWRITE
  input  logic [2:0]                i_size      [`MTX_NUM_PORTS],  // HSIZE
  input  logic [2:0]                i_burst     [`MTX_NUM_PORTS],  // HBURST
  input  logic [`AHB_PROT_W-1:0]    i_prot      [`MTX_NUM_PORTS],  // HPROT
  input  logic [`AHB_MASTER_W-1:0]  i_master    [`MTX_NUM_PORTS],  // HMASTER
  input  logic [`MTX_NUM_PORTS-1:0] i_mastlock,                    // HMASTLOCK
  input  logic [`AHB_DATA_W-1:0]    i_wdata     [`MTX_NUM_PORTS],  // HWDATA
  input  logic [`MTX_NUM_PORTS-1:0] i_held_tran,                   // Held transfer flag

  input  logic                      i_hreadyout,                   // HREADYOUTM
  output logic [`MTX_NUM_PORTS-1:0] o_active,                      // Port owns the slave

  // Slave side
  output logic                      o_hsel,                        // HSELM
  output logic [`AHB_ADDR_W-1:0]    o_haddr,                       // HADDRM
  output htrans_e                   o_htrans,                      // HTRANSM
  output logic                      o_hwrite,                      // HWRITEM
  output logic [2:0]                o_hsize,                       // HSIZEM
  output logic [2:0]                o_hburst,                      // HBURSTM
  output logic [`AHB_PROT_W-1:0]    o_hprot,                       // HPROTM
  output logic [`AHB_MASTER_W-1:0]  o_hmaster,                     // HMASTERM
  output logic                      o_hmastlock,                   // HMASTLOCKM
  output logic                      o_hready_mux,                  // HREADYMUXM
  output logic [`AHB_DATA_W-1:0]    o_hwdata                       // HWDATAM
);

  ahb_ctrl_t                 port_ctrl [`MTX_NUM_PORTS];  // Packed control per port
  ahb_ctrl_t                 slv_ctrl;                    // Granted control
  logic [`MTX_NUM_PORTS-1:0] req;                         // Request per port
  logic                      hready_mux;                  // Internal HREADYMUXM

  ahb_mtx_arb_if arb_if ();                               // Arbiter to mux link

  // ------------------------------------------------
  // Port packing and requests
  // ------------------------------------------------
  always_comb
  begin
    for (int p = 0; p < `MTX_NUM_PORTS; p++)
    begin
      port_ctrl[p].addr     = i_addr[p];
      port_ctrl[p].write    = i_write[p];
      port_ctrl[p].size     = i_size[p];
      port_ctrl[p].burst    = i_burst[p];
      port_ctrl[p].prot     = i_prot[p];
      port_ctrl[p].master   = i_master[p];
      port_ctrl[p].mastlock = i_mastlock[p];
      port_ctrl[p].trans    = i_trans[p];
    end
  end

  assign req = i_held_tran & i_sel;                       // Held and selected

  // ------------------------------------------------
  // Instances
  // ------------------------------------------------
  ahb_mtx_output_arb output_arb_inst (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_req        (req),
    .i_hready_mux (hready_mux),
    .arb          (arb_if.arb)
  );

  ahb_mtx_addr_mux addr_mux_inst (
    .i_ctrl   (port_ctrl),
    .i_sel    (i_sel),
    .mux      (arb_if.mux),
    .o_ctrl   (slv_ctrl),
    .o_sel    (o_hsel),
    .o_active (o_active)
  );

  ahb_mtx_data_phase data_phase_inst (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_hreadyout  (i_hreadyout),
    .i_wdata      (i_wdata),
    .watch        (arb_if.watch),
    .o_hready_mux (hready_mux),
    .o_wdata      (o_hwdata)
  );

  // Slave address and control
  assign o_haddr      = slv_ctrl.addr;
  assign o_htrans     = slv_ctrl.trans;
  assign o_hwrite     = slv_ctrl.write;
  assign o_hsize      = slv_ctrl.size;
  assign o_hburst     = slv_ctrl.burst;
  assign o_hprot      = slv_ctrl.prot;
  assign o_hmaster    = slv_ctrl.master;
  assign o_hmastlock  = slv_ctrl.mastlock;
  assign o_hready_mux = hready_mux;

endmodule

// File: sim/tb_ahb_mtx_model.svh
`ifndef TB_AHB_MTX_MODEL_SVH
`define TB_AHB_MTX_MODEL_SVH

// ------------------------------------------------
// Reference state of the output stage
// ------------------------------------------------
int                      m_grant     = 3;     // Owner code 1..3, port 1 next after reset
logic                    m_no_port   = 1'b1;  // Nothing granted
logic                    m_lock_hold = 1'b0;  // Locked sequence seen
int                      m_data_port = 3;     // Data phase owner code
logic                    m_slave_sel = 1'b0;  // Slave owns the data phase

ahb_ctrl_t               e_ctrl;              // Expected slave control
logic [`MTX_NUM_PORTS-1:0] e_active;          // Expected active flags
logic                    e_hsel;              // Expected HSELM
logic                    e_hready;            // Expected HREADYMUXM
logic [`AHB_DATA_W-1:0]  e_hwdata;            // Expected HWDATAM

// Slave side values for the current cycle
task model_eval();
  int o;
  o        = m_grant - 1;
  e_ctrl   = '0;
  e_ctrl.trans = IDLE;                        // Idle slave when unowned
  e_hsel   = 1'b0;
  e_active = '0;
  if (!m_no_port)
  begin
    e_ctrl.addr     = i_addr[o];
    e_ctrl.write    = i_write[o];
    e_ctrl.size     = i_size[o];
    e_ctrl.burst    = i_burst[o];
    e_ctrl.prot     = i_prot[o];
    e_ctrl.master   = i_master[o];
    e_ctrl.mastlock = i_mastlock[o];
    e_ctrl.trans    = i_trans[o];
    e_hsel          = i_sel[o];
    e_active[o]     = 1'b1;
  end
  e_hready = m_slave_sel ? i_hreadyout : 1'b1;  // Slave ready only in its data phase
  e_hwdata = i_wdata[m_data_port - 1];
endtask

// State update for the coming rising edge
task model_step();
  logic [`MTX_NUM_PORTS-1:0] req;
  logic                      burst;
  logic                      lock_eff;
  logic                      next_lock;
  logic                      found;
  int                        cand;
  int                        next_grant;
  req = i_held_tran & i_sel;
  if (!HRESETn)
  begin
    m_grant     = 3;
    m_no_port   = 1'b1;
    m_lock_hold = 1'b0;
    m_data_port = 3;
    m_slave_sel = 1'b0;
  end
  else if (e_hready)                          // Everything frozen in wait states
  begin
    next_lock = m_lock_hold;
    if (e_hsel && e_ctrl.mastlock && (e_ctrl.trans == NONSEQ || e_ctrl.trans == SEQ))
      next_lock = 1'b1;
    else if (!e_ctrl.mastlock)
      next_lock = 1'b0;
    lock_eff = e_ctrl.mastlock && (m_lock_hold || e_hsel);
    burst    = !m_no_port && req[m_grant - 1] &&
               (e_ctrl.trans == SEQ || e_ctrl.trans == BUSY);
    m_data_port = m_grant;                    // Address phase moves to data phase
    m_slave_sel = e_hsel && !m_no_port;
    if (burst || lock_eff)
      m_no_port = 1'b0;
    else
    begin
      found      = 1'b0;
      next_grant = m_grant;
      for (int k = 1; k <= `MTX_NUM_PORTS; k++)
      begin
        cand = (m_grant - 1 + k) % `MTX_NUM_PORTS;  // Next after owner, owner last
        if (!found && req[cand])
        begin
          found      = 1'b1;
          next_grant = cand + 1;
        end
      end
      m_no_port = !found;
      m_grant   = next_grant;                 // Unchanged when nobody asks
    end
    m_lock_hold = next_lock;
  end
endtask

// Full slave side comparison
task compare_model();
  check_val("o_active", e_active, o_active);
  check_val("o_hsel", e_hsel, o_hsel);
  check_val("o_haddr", e_ctrl.addr, o_haddr);
  check_val("o_htrans", e_ctrl.trans, o_htrans);
  check_val("o_hwrite", e_ctrl.write, o_hwrite);
  check_val("o_hsize", e_ctrl.size, o_hsize);
  check_val("o_hburst", e_ctrl.burst, o_hburst);
  check_val("o_hprot", e_ctrl.prot, o_hprot);
  check_val("o_hmaster", e_ctrl.master, o_hmaster);
  check_val("o_hmastlock", e_ctrl.mastlock, o_hmastlock);
  check_val("o_hready_mux", e_hready, o_hready_mux);
  check_val("o_hwdata", e_hwdata, o_hwdata);
endtask

`endif

// File: sim/tb_ahb_mtx_output_stage.sv
`timescale 1ns/1ps
`include "ahb_mtx_params.svh"

module tb_ahb_mtx_output_stage
  import ahb_mtx_pkg::*;
();

  logic                      HCLK;
  logic                      HRESETn;
  logic [`MTX_NUM_PORTS-1:0] i_sel;
  logic [`AHB_ADDR_W-1:0]    i_addr   [`MTX_NUM_PORTS];
  htrans_e                   i_trans  [`MTX_NUM_PORTS];
  logic [`MTX_NUM_PORTS-1:0] i_write;
  logic [2:0]                i_size   [`MTX_NUM_PORTS];
  logic [2:0]                i_burst  [`MTX_NUM_PORTS];
  logic [`AHB_PROT_W-1:0]    i_prot   [`MTX_NUM_PORTS];
  logic [`AHB_MASTER_W-1:0]  i_master [`MTX_NUM_PORTS];
  logic [`MTX_NUM_PORTS-1:0] i_mastlock;
  logic [`AHB_DATA_W-1:0]    i_wdata  [`MTX_NUM_PORTS];
  logic [`MTX_NUM_PORTS-1:0] i_held_tran;
  logic                      i_hreadyout;
  logic [`MTX_NUM_PORTS-1:0] o_active;
  logic                      o_hsel;
  logic [`AHB_ADDR_W-1:0]    o_haddr;
  htrans_e                   o_htrans;
  logic                      o_hwrite;
  logic [2:0]                o_hsize;
  logic [2:0]                o_hburst;
  logic [`AHB_PROT_W-1:0]    o_hprot;
  logic [`AHB_MASTER_W-1:0]  o_hmaster;
  logic                      o_hmastlock;
  logic                      o_hready_mux;
  logic [`AHB_DATA_W-1:0]    o_hwdata;

  int   checks   = 0;     // Compares made
  int   errors   = 0;     // Compares failed
  logic check_en = 1'b0;  // Model compare armed after reset
  int   seed;             // Return of the seeding call

  `include "tb_ahb_mtx_model.svh"

  ahb_mtx_output_stage ahb_mtx_output_stage_inst (.*);

  initial HCLK = 1'b0;
  always #50 HCLK = ~HCLK;  // 100 ns period

  // ------------------------------------------------
  // Helpers
  // ------------------------------------------------
  task check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %s expected 0x%0h got 0x%0h at %0t ns", name, exp, got, $time);
    end
  endtask

  task close_test(input string name, input int start);
    $display("test %-8s done, %0d errors", name, errors - start);
  endtask

  // Directed port setup with fixed address and data per port
  task set_port(input int p, input logic sel, input logic held, input htrans_e trans,
                input logic lock);
    i_sel[p]       <= sel;
    i_held_tran[p] <= held;
    i_trans[p]     <= trans;
    i_mastlock[p]  <= lock;
    i_addr[p]      <= 32'h2000_0000 + 32'(p) * 32'h40;
    i_write[p]     <= 1'b1;
    i_size[p]      <= 3'd2;
    i_burst[p]     <= 3'd0;
    i_prot[p]      <= 4'h3;
    i_master[p]    <= 4'(p + 1);
    i_wdata[p]     <= 32'hcafe_0000 + 32'(p);
  endtask

  task idle_ports();
    for (int p = 0; p < `MTX_NUM_PORTS; p++)
      set_port(p, 1'b0, 1'b0, IDLE, 1'b0);
  endtask

  // Model runs between edges while inputs are stable
  always @(negedge HCLK)
  begin
    model_eval();
    if (check_en)
      compare_model();
    model_step();
  end

  // ------------------------------------------------
  // Tests
  // ------------------------------------------------
  task reset_test();
    int start;
    start = errors;
    check_en = 1'b1;
    @(negedge HCLK);
    check_val("o_active", '0, o_active);
    check_val("o_hsel", 1'b0, o_hsel);
    check_val("o_htrans", IDLE, o_htrans);
    check_val("o_hmastlock", 1'b0, o_hmastlock);
    check_val("o_hready_mux", 1'b1, o_hready_mux);
    close_test("reset", start);
  endtask

  task rotation_test();
    int start;
    start = errors;
    @(posedge HCLK);
    for (int p = 0; p < `MTX_NUM_PORTS; p++)
      set_port(p, 1'b1, 1'b1, NONSEQ, 1'b0);
    @(negedge HCLK);
    check_val("o_active", '0, o_active);         // Request not yet seen
    for (int i = 0; i < 4; i++)
    begin
      @(negedge HCLK);
      check_val("o_active", 3'b001 << (i % 3), o_active);  // 1, 2, 3, 1
    end
    close_test("rotation", start);
  endtask

  task stall_test();
    int                        start;
    logic [`MTX_NUM_PORTS-1:0] hold_act;
    logic [`AHB_DATA_W-1:0]    hold_wdata;
    start = errors;
    @(posedge HCLK);
    i_hreadyout <= 1'b0;                          // Slave inserts wait states
    @(negedge HCLK);
    hold_act   = o_active;
    hold_wdata = o_hwdata;
    check_val("o_hready_mux", 1'b0, o_hready_mux);
    repeat (4)
    begin
      @(negedge HCLK);
      check_val("o_hready_mux", 1'b0, o_hready_mux);
      check_val("o_active", hold_act, o_active);
      check_val("o_hwdata", hold_wdata, o_hwdata);
    end
    @(posedge HCLK);
    i_hreadyout <= 1'b1;
    @(negedge HCLK);
    while (!o_hready_mux)                         // Wait out the last stall
      @(negedge HCLK);
    close_test("stall", start);
  endtask

  task lock_test();
    int start;
    start = errors;
    @(posedge HCLK);
    idle_ports();
    @(posedge HCLK);
    set_port(0, 1'b1, 1'b1, NONSEQ, 1'b1);        // Port 1 alone opens a lock
    @(posedge HCLK);
    set_port(0, 1'b1, 1'b1, SEQ, 1'b1);
    set_port(1, 1'b1, 1'b1, NONSEQ, 1'b0);        // Competitors arrive
    set_port(2, 1'b1, 1'b1, NONSEQ, 1'b0);
    repeat (2)
    begin
      @(negedge HCLK);
      check_val("o_active", 3'b001, o_active);
    end
    @(posedge HCLK);
    set_port(0, 1'b0, 1'b0, IDLE, 1'b1);          // Leaves this slave mid lock
    repeat (2)
    begin
      @(negedge HCLK);
      check_val("o_active", 3'b001, o_active);
    end
    @(posedge HCLK);
    set_port(0, 1'b1, 1'b1, SEQ, 1'b1);
    @(negedge HCLK);
    check_val("o_active", 3'b001, o_active);
    @(posedge HCLK);
    set_port(0, 1'b0, 1'b0, IDLE, 1'b0);          // Lock dropped
    @(negedge HCLK);
    check_val("o_active", 3'b001, o_active);
    @(negedge HCLK);
    check_val("o_active", 3'b010, o_active);      // Released to port 2
    close_test("lock", start);
  endtask

  task random_test();
    int start;
    start = errors;
    for (int c = 0; c < 400; c++)
    begin
      @(posedge HCLK);
      for (int p = 0; p < `MTX_NUM_PORTS; p++)
      begin
        i_sel[p]       <= ($urandom_range(3) != 0);
        i_held_tran[p] <= ($urandom_range(3) != 0);
        i_trans[p]     <= htrans_e'($urandom_range(3));
        i_mastlock[p]  <= ($urandom_range(7) == 0);  // Short locked runs
        i_addr[p]      <= $urandom();
        i_write[p]     <= 1'($urandom_range(1));
        i_size[p]      <= 3'($urandom_range(7));
        i_burst[p]     <= 3'($urandom_range(7));
        i_prot[p]      <= 4'($urandom_range(15));
        i_master[p]    <= 4'($urandom_range(15));
        i_wdata[p]     <= $urandom();
      end
      i_hreadyout <= ($urandom_range(3) != 0);       // About one wait in four
    end
    @(negedge HCLK);
    close_test("random", start);
  endtask

  // ------------------------------------------------
  // Main sequence and watchdog
  // ------------------------------------------------
  initial
  begin
    seed = $urandom(22489);
    HRESETn     <= 1'b0;
    i_hreadyout <= 1'b1;
    idle_ports();
    repeat (16) @(posedge HCLK);
    HRESETn <= 1'b1;
    reset_test();
    rotation_test();
    stall_test();
    lock_test();
    random_test();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    #((16 + 600) * 200);
    $display("Timeout, the run did not finish within %0d ns", (16 + 600) * 200);
    $display("Test failed");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+hdl
+incdir+sim
hdl/ahb_mtx_pkg.sv
hdl/ahb_mtx_arb_if.sv
hdl/ahb_mtx_output_arb.sv
hdl/ahb_mtx_addr_mux.sv
hdl/ahb_mtx_data_phase.sv
hdl/ahb_mtx_output_stage.sv
sim/tb_ahb_mtx_output_stage.sv
